// ==== oric_glue_pkg.sv ====
`default_nettype none

package oric_glue_pkg;

	// download stream from the data_io side
	typedef struct packed {
		logic        downl;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
	} dl_write_t;

	typedef struct packed {
		logic [15:0] ram_ad;
		logic [7:0]  ram_d;
		logic        ram_cs;
		logic        ram_oe;
		logic        ram_we;
		logic [15:0] rom_ad;
		logic        rom_cs;
		logic        rom_ext_cs;
	} cpu_bus_t;

	// toggle request for sdram port 1
	typedef struct packed {
		logic        req;
		logic [15:0] a;     // word address
		logic [1:0]  ds;
		logic        we;
		logic [15:0] d;
	} mem_req_t;

	typedef struct packed {
		logic [13:0] mono;
		logic [11:0] a;
		logic [11:0] b;
		logic [11:0] c;
	} psg_t;

	typedef enum logic [1:0] {
		STEREO_OFF = 2'd0,
		STEREO_ABC = 2'd1,
		STEREO_ACB = 2'd2
	} stereo_e;

	typedef struct packed {
		logic        reset_req;
		logic        tape_play;
		logic        rom_sel;    // 1 = atmos
		logic [1:0]  scanlines;
		logic        disk_en;
		logic        write_prot;
		stereo_e     stereo;
		logic [1:0]  cpu_type;
	} osd_status_t;

	// bit positions in the osd status word
	localparam int ST_RESET     = 0;
	localparam int ST_TAPE_PLAY = 1;
	localparam int ST_ROM       = 3;
	localparam int ST_SCAN      = 4;
	localparam int ST_DISK      = 6;
	localparam int ST_WP        = 7;
	localparam int ST_STEREO    = 8;
	localparam int ST_CPU       = 10;

	localparam int RAM_BANK_BIT = 16;
	localparam logic [15:0] MICRODISK_BASE = 16'h8000;

	function automatic logic is_rom_index(input logic [7:0] idx);
		return (idx == 8'd0) || (idx == 8'd1);
	endfunction

	function automatic logic is_tap_index(input logic [7:0] idx);
		return idx == 8'd3;
	endfunction

endpackage

`default_nettype wire

// ==== machine_ctrl.sv ====
`default_nettype none

module machine_ctrl import oric_glue_pkg::*; (
	input  wire               clk_72,
	input  wire               rst_n_i,
	input  wire [31:0]        status_i,
	input  wire               button_reset_i,
	input  wire dl_write_t    dl_i,
	input  wire               fd_led_i,
	input  wire               img_mounted_i,
	input  wire [31:0]        img_size_i,
	output osd_status_t       status_o,
	output logic              reset_o,
	output logic              disk_ready_o,
	output logic              led_o
);

	logic old_rom;
	logic old_disk;
	logic old_mounted;
	logic rom_downl;

	always_comb begin
		status_o.reset_req  = status_i[ST_RESET];
		status_o.tape_play  = status_i[ST_TAPE_PLAY];
		status_o.rom_sel    = ~status_i[ST_ROM];
		status_o.scanlines  = status_i[ST_SCAN +: 2];
		status_o.disk_en    = status_i[ST_DISK];
		status_o.write_prot = status_i[ST_WP];
		status_o.stereo     = stereo_e'(status_i[ST_STEREO +: 2]);
		status_o.cpu_type   = status_i[ST_CPU +: 2];
	end

	assign rom_downl = dl_i.downl & is_rom_index(dl_i.index);

	// machine held in reset one cycle after any of these
	always_ff @(posedge clk_72) begin
		if (!rst_n_i) begin
			old_rom  <= status_o.rom_sel;
			old_disk <= status_o.disk_en;
			reset_o  <= 1'b1;
		end else begin
			old_rom  <= status_o.rom_sel;
			old_disk <= status_o.disk_en;
			reset_o  <= status_o.reset_req | button_reset_i |
				(old_rom != status_o.rom_sel) |
				(old_disk != status_o.disk_en) | rom_downl;
		end
	end

	always_ff @(posedge clk_72) begin
		if (!rst_n_i) begin
			old_mounted  <= 1'b0;
			disk_ready_o <= 1'b0;
		end else begin
			old_mounted <= img_mounted_i;
			if (img_mounted_i && !old_mounted)
				disk_ready_o <= |img_size_i; // empty image means no disk
		end
	end

	assign led_o = ~fd_led_i & ~dl_i.downl; // low active

endmodule

`default_nettype wire

// ==== main_mem_port.sv ====
`default_nettype none

module main_mem_port import oric_glue_pkg::*; (
	input  wire             clk_72,
	input  wire             rst_n_i,
	input  wire dl_write_t  dl_i,
	input  wire cpu_bus_t   cpu_i,
	input  wire             rom_atmos_i,
	output mem_req_t        mem1_o,
	input  wire [15:0]      mem1_q_i,
	output logic [7:0]      cpu_q_o
);

	logic        req;
	logic        we;
	logic [16:0] byte_ad;   // bit 16 set for ram
	logic [7:0]  din;

	logic        ram_we_old;
	logic        ram_oe_old;
	logic [15:0] ram_ad_old;
	logic        rom_cs_old;
	logic        rom_ext_cs_old;
	logic [15:0] rom_ad_old;

	logic        rom_downl;
	logic        ram_rd;
	logic        ram_wr;
	logic        ram_trig;
	logic        rom_trig;
	logic [16:0] rom_sd_ad;
	logic [7:0]  q_byte;

	assign rom_downl = dl_i.downl & is_rom_index(dl_i.index);
	assign ram_rd    = cpu_i.ram_cs & cpu_i.ram_oe;
	assign ram_wr    = cpu_i.ram_cs & cpu_i.ram_we;

	assign ram_trig = (ram_rd & ~ram_oe_old) | (ram_wr & ~ram_we_old) |
		(ram_rd & (cpu_i.ram_ad != ram_ad_old));
	assign rom_trig = (cpu_i.rom_cs & ~rom_cs_old) | (cpu_i.rom_ext_cs & ~rom_ext_cs_old) |
		((cpu_i.rom_cs | cpu_i.rom_ext_cs) & (cpu_i.rom_ad != rom_ad_old));

	// 0000-7fff oric-1 / atmos, 8000-9fff microdisk
	assign rom_sd_ad = cpu_i.rom_cs ? {2'b00, rom_atmos_i, cpu_i.rom_ad[13:0]} :
		{1'b0, MICRODISK_BASE | {3'b000, cpu_i.rom_ad[12:0]}};

	always_ff @(posedge clk_72) begin
		if (!rst_n_i) begin
			req            <= 1'b0;
			we             <= 1'b0;
			ram_we_old     <= 1'b0;
			ram_oe_old     <= 1'b0;
			rom_cs_old     <= 1'b0;
			rom_ext_cs_old <= 1'b0;
		end else begin
			ram_we_old     <= ram_wr;
			ram_oe_old     <= ram_rd;
			rom_cs_old     <= cpu_i.rom_cs;
			rom_ext_cs_old <= cpu_i.rom_ext_cs;
			if (rom_downl) begin
				if (dl_i.wr) begin
					req <= ~req;
					we  <= 1'b1;
				end
			end else if (rom_trig) begin
				req <= ~req; // rom fetch beats a ram access
				we  <= 1'b0;
			end else if (ram_trig) begin
				req <= ~req;
				we  <= cpu_i.ram_we;
			end
		end
	end

	always_ff @(posedge clk_72) begin
		ram_ad_old <= cpu_i.ram_ad;
		rom_ad_old <= cpu_i.rom_ad;
		if (rom_downl) begin
			if (dl_i.wr) begin
				byte_ad <= dl_i.addr[16:0];
				din     <= dl_i.dout;
			end
		end else if (rom_trig) begin
			byte_ad <= rom_sd_ad;
		end else if (ram_trig) begin
			byte_ad <= 17'(cpu_i.ram_ad) | (17'd1 << RAM_BANK_BIT);
			din     <= cpu_i.ram_d;
		end
	end

	assign mem1_o.req = req;
	assign mem1_o.a   = byte_ad[16:1];
	assign mem1_o.ds  = we ? (byte_ad[0] ? 2'b10 : 2'b01) : 2'b11;
	assign mem1_o.we  = we;
	assign mem1_o.d   = {din, din};

	assign q_byte = byte_ad[0] ? mem1_q_i[15:8] : mem1_q_i[7:0];

	// nothing selected reads as zero
	assign cpu_q_o = (cpu_i.ram_cs | cpu_i.rom_cs | cpu_i.rom_ext_cs) ? q_byte : 8'd0;

endmodule

`default_nettype wire

// ==== tape_fetch.sv ====
`default_nettype none

module tape_fetch import oric_glue_pkg::*; #(
	parameter int TAPE_ADDR_W = 24
) (
	input  wire                     clk_72,
	input  wire                     rst_n_i,
	input  wire dl_write_t          dl_i,
	output logic                    tap_req_o,
	output logic                    tap_we_o,
	output logic [TAPE_ADDR_W-2:0]  tap_a_o,
	output logic [1:0]              tap_ds_o,
	output logic [15:0]             tap_d_o,
	input  wire                     tap_ack_i,
	input  wire [15:0]              tap_q_i,
	input  wire                     byte_req_i,
	input  wire [TAPE_ADDR_W-1:0]   byte_addr_i,
	output logic                    byte_ack_o,
	output logic [7:0]              byte_o,
	output logic [TAPE_ADDR_W-1:0]  tape_last_o
);

	logic                   tap_downl;
	logic                   port_idle;
	logic                   byte_pend;
	logic                   rd_issued;  // read sent and waiting for the next idle slot
	logic [TAPE_ADDR_W-1:0] wr_ad;
	logic [7:0]             wr_d;

	assign tap_downl = dl_i.downl & is_tap_index(dl_i.index);
	assign port_idle = tap_req_o == tap_ack_i;
	assign byte_pend = byte_req_i ^ byte_ack_o;

	always_ff @(posedge clk_72) begin
		if (!rst_n_i) begin
			tap_req_o   <= 1'b0;
			tap_we_o    <= 1'b0;
			byte_ack_o  <= 1'b0;
			rd_issued   <= 1'b0;
			tape_last_o <= '0;
		end else if (tap_downl) begin
			rd_issued <= 1'b0;
			if (dl_i.wr) begin
				tap_req_o   <= ~tap_req_o;
				tap_we_o    <= 1'b1;
				tape_last_o <= dl_i.addr[TAPE_ADDR_W-1:0];
			end
		end else begin
			tap_we_o <= 1'b0;
			if (byte_pend && port_idle) begin
				if (!rd_issued) begin
					if (byte_addr_i <= tape_last_o) begin // past the end stays pending
						tap_req_o <= ~tap_req_o;
						rd_issued <= 1'b1;
					end
				end else begin
					byte_ack_o <= byte_req_i;
					rd_issued  <= 1'b0;
				end
			end
		end
	end

	// write payload held for the sdram side
	always_ff @(posedge clk_72) begin
		if (tap_downl && dl_i.wr) begin
			wr_ad <= dl_i.addr[TAPE_ADDR_W-1:0];
			wr_d  <= dl_i.dout;
		end
	end

	assign tap_a_o  = tap_we_o ? wr_ad[TAPE_ADDR_W-1:1] : byte_addr_i[TAPE_ADDR_W-1:1];
	assign tap_ds_o = tap_we_o ? (wr_ad[0] ? 2'b10 : 2'b01) : 2'b11;
	assign tap_d_o  = {wr_d, wr_d};

	assign byte_o = byte_addr_i[0] ? tap_q_i[15:8] : tap_q_i[7:0];

endmodule

`default_nettype wire

// ==== psg_stereo_mix.sv ====
`default_nettype none

module psg_stereo_mix import oric_glue_pkg::*; (
	input  wire           clk_72,
	input  wire           rst_n_i,
	input  wire psg_t     psg_i,
	input  wire stereo_e  stereo_i,
	output logic [15:0]   audio_l_o,
	output logic [15:0]   audio_r_o
);

	logic [15:0] a_ext;
	logic [15:0] b_ext;
	logic [15:0] c_ext;
	logic [15:0] mono_ext;

	assign a_ext    = {2'b00, psg_i.a, 2'b00};
	assign b_ext    = {2'b00, psg_i.b, 2'b00};
	assign c_ext    = {2'b00, psg_i.c, 2'b00};
	assign mono_ext = {1'b0, psg_i.mono, 1'b0};

	always_ff @(posedge clk_72) begin
		if (!rst_n_i) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			case (stereo_i)
				STEREO_ABC: begin
					audio_l_o <= a_ext + b_ext;
					audio_r_o <= c_ext + b_ext;
				end
				STEREO_ACB: begin
					audio_l_o <= a_ext + c_ext;
					audio_r_o <= c_ext + b_ext; // east europe layout
				end
				default: begin
					audio_l_o <= mono_ext;
					audio_r_o <= mono_ext;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== oric_board_glue.sv ====
`default_nettype none

module oric_board_glue import oric_glue_pkg::*; #(
	parameter int TAPE_ADDR_W = 24   // 23 on the 8 MB sdram
) (
	input  wire                     clk_72,
	input  wire                     rst_n_i,
	input  wire [31:0]              status_i,
	input  wire                     button_reset_i,
	input  wire dl_write_t          dl_i,
	input  wire cpu_bus_t           cpu_i,
	output logic [7:0]              cpu_q_o,
	input  wire psg_t               psg_i,
	input  wire                     fd_led_i,
	input  wire                     img_mounted_i,
	input  wire [31:0]              img_size_i,
	output mem_req_t                mem1_o,
	input  wire [15:0]              mem1_q_i,
	output logic                    tap_req_o,
	output logic                    tap_we_o,
	output logic [TAPE_ADDR_W-2:0]  tap_a_o,
	output logic [1:0]              tap_ds_o,
	output logic [15:0]             tap_d_o,
	input  wire                     tap_ack_i,
	input  wire [15:0]              tap_q_i,
	input  wire                     byte_req_i,
	input  wire [TAPE_ADDR_W-1:0]   byte_addr_i,
	output logic                    byte_ack_o,
	output logic [7:0]              byte_o,
	output logic [TAPE_ADDR_W-1:0]  tape_last_o,
	output logic                    reset_o,
	output logic                    disk_ready_o,
	output logic [1:0]              cpu_type_o,
	output logic                    write_protect_o,
	output logic                    tape_play_o,
	output logic [15:0]             audio_l_o,
	output logic [15:0]             audio_r_o,
	output logic                    led_o
);

	osd_status_t osd;

	machine_ctrl u_machine_ctrl (
		.clk_72         (clk_72),
		.rst_n_i        (rst_n_i),
		.status_i       (status_i),
		.button_reset_i (button_reset_i),
		.dl_i           (dl_i),
		.fd_led_i       (fd_led_i),
		.img_mounted_i  (img_mounted_i),
		.img_size_i     (img_size_i),
		.status_o       (osd),
		.reset_o        (reset_o),
		.disk_ready_o   (disk_ready_o),
		.led_o          (led_o)
	);

	main_mem_port u_main_mem_port (
		.clk_72      (clk_72),
		.rst_n_i     (rst_n_i),
		.dl_i        (dl_i),
		.cpu_i       (cpu_i),
		.rom_atmos_i (osd.rom_sel),
		.mem1_o      (mem1_o),
		.mem1_q_i    (mem1_q_i),
		.cpu_q_o     (cpu_q_o)
	);

	tape_fetch #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) u_tape_fetch (
		.clk_72      (clk_72),
		.rst_n_i     (rst_n_i),
		.dl_i        (dl_i),
		.tap_req_o   (tap_req_o),
		.tap_we_o    (tap_we_o),
		.tap_a_o     (tap_a_o),
		.tap_ds_o    (tap_ds_o),
		.tap_d_o     (tap_d_o),
		.tap_ack_i   (tap_ack_i),
		.tap_q_i     (tap_q_i),
		.byte_req_i  (byte_req_i),
		.byte_addr_i (byte_addr_i),
		.byte_ack_o  (byte_ack_o),
		.byte_o      (byte_o),
		.tape_last_o (tape_last_o)
	);

	psg_stereo_mix u_psg_stereo_mix (
		.clk_72    (clk_72),
		.rst_n_i   (rst_n_i),
		.psg_i     (psg_i),
		.stereo_i  (osd.stereo),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

	// osd fields going to the core
	assign cpu_type_o      = osd.cpu_type;
	assign write_protect_o = osd.write_prot;
	assign tape_play_o     = osd.tape_play;

endmodule

`default_nettype wire

// ==== oric_board_glue_assert.sv ====
`default_nettype none

module oric_board_glue_assert import oric_glue_pkg::*; (
	input wire            clk_72,
	input wire            rst_n_i,
	input wire dl_write_t dl_i,
	input wire mem_req_t  mem1_o,
	input wire            tap_req_o,
	input wire            tap_we_o,
	input wire            tap_ack_i
);

	// rom download write toggles port 1 on the next edge
	property p_rom_dl_toggle;
		@(posedge clk_72) disable iff (!rst_n_i)
		dl_i.downl && is_rom_index(dl_i.index) && dl_i.wr |=> mem1_o.req != $past(mem1_o.req);
	endproperty

	property p_tap_dl_toggle;
		@(posedge clk_72) disable iff (!rst_n_i)
		dl_i.downl && is_tap_index(dl_i.index) && dl_i.wr |=> tap_req_o != $past(tap_req_o);
	endproperty

	// playback read only starts from an idle port 2
	property p_tap_one_outstanding;
		@(posedge clk_72) disable iff (!rst_n_i)
		(tap_req_o != $past(tap_req_o)) && !tap_we_o |-> $past(tap_req_o == tap_ack_i);
	endproperty

	a_rom_dl_toggle: assert property (p_rom_dl_toggle)
		else $error("port 1 request did not toggle after rom download write");
	a_tap_dl_toggle: assert property (p_tap_dl_toggle)
		else $error("port 2 request did not toggle after tape download write");
	a_tap_one_outstanding: assert property (p_tap_one_outstanding)
		else $error("port 2 read issued while a request was outstanding");

endmodule

bind oric_board_glue oric_board_glue_assert u_assert (
	.clk_72    (clk_72),
	.rst_n_i   (rst_n_i),
	.dl_i      (dl_i),
	.mem1_o    (mem1_o),
	.tap_req_o (tap_req_o),
	.tap_we_o  (tap_we_o),
	.tap_ack_i (tap_ack_i)
);

`default_nettype wire

// ==== tb_oric_board_glue.sv ====
`default_nettype none

module tb_oric_board_glue import oric_glue_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int TEST_CYCLES = 60 + 20 + 200 + 120 + 400 + 60 + 40; // per test, rough
	localparam logic [23:0] TBASE = 24'h00c000;
	localparam int NTAPE = 12;

	logic clk_72, rst_n_i, button_reset_i, fd_led_i, img_mounted_i;
	logic [31:0] status_i, img_size_i;
	dl_write_t dl;
	cpu_bus_t cpu;
	psg_t psg;
	mem_req_t mem1;
	logic [15:0] mem1_q_i, tap_d_o, tap_q_i, audio_l_o, audio_r_o;
	logic [7:0] cpu_q_o, byte_o;
	logic tap_req_o, tap_we_o, tap_ack_i, byte_req_i, byte_ack_o;
	logic [22:0] tap_a_o;
	logic [1:0] tap_ds_o, cpu_type_o;
	logic [23:0] byte_addr_i, tape_last_o;
	logic reset_o, disk_ready_o, write_protect_o, tape_play_o, led_o;

	logic [15:0] sdram [0:65535];
	logic p1_seen;
	int seed = 32'h13cd_53ad;
	int errors = 0;
	int tests = 0;
	logic [7:0] rom_ref [int];
	logic [7:0] ram_ref [int];
	logic [7:0] tape_ref [NTAPE];

	oric_board_glue UUT (
		.clk_72(clk_72), .rst_n_i(rst_n_i), .status_i(status_i),
		.button_reset_i(button_reset_i), .dl_i(dl), .cpu_i(cpu), .cpu_q_o(cpu_q_o),
		.psg_i(psg), .fd_led_i(fd_led_i), .img_mounted_i(img_mounted_i),
		.img_size_i(img_size_i), .mem1_o(mem1), .mem1_q_i(mem1_q_i),
		.tap_req_o(tap_req_o), .tap_we_o(tap_we_o), .tap_a_o(tap_a_o),
		.tap_ds_o(tap_ds_o), .tap_d_o(tap_d_o), .tap_ack_i(tap_ack_i), .tap_q_i(tap_q_i),
		.byte_req_i(byte_req_i), .byte_addr_i(byte_addr_i), .byte_ack_o(byte_ack_o),
		.byte_o(byte_o), .tape_last_o(tape_last_o), .reset_o(reset_o),
		.disk_ready_o(disk_ready_o), .cpu_type_o(cpu_type_o),
		.write_protect_o(write_protect_o), .tape_play_o(tape_play_o),
		.audio_l_o(audio_l_o), .audio_r_o(audio_r_o), .led_o(led_o)
	);

	initial begin
		clk_72 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_72 = ~clk_72;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	// port 1 model answers on the edge after the toggle
	always @(posedge clk_72) begin
		if (mem1.req != p1_seen) begin
			p1_seen <= mem1.req;
			if (mem1.we) begin
				if (mem1.ds[0]) sdram[mem1.a][7:0] <= mem1.d[7:0];
				if (mem1.ds[1]) sdram[mem1.a][15:8] <= mem1.d[15:8];
			end else begin
				mem1_q_i <= sdram[mem1.a];
			end
		end
	end

	// port 2 with random ack latency
	initial begin : port2_model
		logic we;
		logic [15:0] wa, wd;
		logic [1:0] ds;
		int lat;
		forever begin
			@(posedge clk_72);
			if (rst_n_i && tap_req_o !== tap_ack_i) begin
				we = tap_we_o;
				wa = tap_a_o[15:0];
				wd = tap_d_o;
				ds = tap_ds_o;
				lat = $unsigned($random(seed)) % 4;
				repeat (lat) @(posedge clk_72);
				if (we) begin
					if (ds[0]) sdram[wa][7:0] <= wd[7:0];
					if (ds[1]) sdram[wa][15:8] <= wd[15:8];
				end else begin
					tap_q_i <= sdram[wa];
				end
				tap_ack_i <= tap_req_o;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic settle();
		@(posedge clk_72);
		@(negedge clk_72);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s finished, errors so far %0d", name, errors);
	endtask

	task automatic reset_cause(input int which);
		@(posedge clk_72);
		case (which)
			0: status_i[0] <= 1'b1;
			1: button_reset_i <= 1'b1;
			2: status_i[3] <= ~status_i[3];
			3: status_i[6] <= ~status_i[6];
			default: dl <= '{downl: 1'b1, index: 8'd1, wr: 1'b0, addr: '0, dout: '0};
		endcase
		settle();
		check("reset_o", 32'(reset_o), 32'd1);
		@(posedge clk_72);
		status_i[0] <= 1'b0;
		button_reset_i <= 1'b0;
		dl.downl <= 1'b0;
		settle();
		check("reset_o", 32'(reset_o), 32'd0);
	endtask

	task automatic fetch_rom(input logic [15:0] ba, output logic [7:0] q);
		@(posedge clk_72);
		cpu.rom_cs <= ~ba[15];
		cpu.rom_ext_cs <= ba[15];
		cpu.rom_ad <= ba[15] ? {3'b000, ba[12:0]} : {2'b00, ba[13:0]};
		if (!ba[15]) status_i[3] <= ~ba[14]; // atmos rom in the upper 16K
		settle();
		settle();
		q = cpu_q_o;
		@(posedge clk_72);
		cpu.rom_cs <= 1'b0;
		cpu.rom_ext_cs <= 1'b0;
	endtask

	task automatic wait_tape_idle();
		int n;
		n = 0;
		while (tap_req_o !== tap_ack_i && n < 50) begin
			@(negedge clk_72);
			n++;
		end
		if (n == 50) begin
			$display("port 2 acknowledge never arrived at %0t", $time);
			errors++;
		end
	endtask

	initial begin : stimulus
		logic [15:0] ba;
		logic [7:0] bd, q;
		logic exp_req;
		int n;
		logic [15:0] ea, eb, ec, em;
		rst_n_i = 1'b0;
		status_i = '0;
		button_reset_i = 1'b0;
		fd_led_i = 1'b0;
		img_mounted_i = 1'b0;
		img_size_i = '0;
		dl = '0;
		cpu = '0;
		psg = '0;
		mem1_q_i = '0;
		tap_ack_i = 1'b0;
		tap_q_i = '0;
		byte_req_i = 1'b0;
		byte_addr_i = '0;
		p1_seen = 1'b0;
		repeat (3) @(posedge clk_72);
		rst_n_i <= 1'b1;
		settle();

		for (int c = 0; c < 5; c++) reset_cause(c);
		finish_test("reset generation");

		for (int k = 0; k < 4; k++) begin
			@(posedge clk_72);
			status_i[1] <= k[0];
			status_i[7] <= k[1];
			status_i[11:10] <= 2'(3 - k);
			@(negedge clk_72);
			check("tape_play_o", 32'(tape_play_o), 32'(k[0]));
			check("write_protect_o", 32'(write_protect_o), 32'(k[1]));
			check("cpu_type_o", 32'(cpu_type_o), 32'(3 - k));
		end
		finish_test("status decode");

		exp_req = 1'b0; // request toggle is 0 out of reset
		for (int i = 0; i < 16; i++) begin
			ba = 16'((i % 3) * 16'h4000) + 16'($random(seed) & 32'h1fff);
			bd = 8'($random(seed));
			rom_ref[int'(ba)] = bd;
			exp_req = ~exp_req;
			@(posedge clk_72);
			dl <= '{downl: 1'b1, index: 8'd0, wr: 1'b1, addr: 25'(ba), dout: bd};
			@(posedge clk_72);
			dl.wr <= 1'b0;
			@(negedge clk_72);
			check("mem1.req", 32'(mem1.req), 32'(exp_req));
			check("mem1.we", 32'(mem1.we), 32'd1);
			check("mem1.a", 32'(mem1.a), 32'(ba[15:1]));
			check("mem1.ds", 32'(mem1.ds), ba[0] ? 32'd2 : 32'd1);
			check("mem1.d", 32'(mem1.d), 32'({bd, bd}));
		end
		@(posedge clk_72);
		dl.downl <= 1'b0;
		foreach (rom_ref[a]) begin
			fetch_rom(16'(a), q);
			check("cpu_q_o rom", 32'(q), 32'(rom_ref[a]));
		end
		finish_test("rom download");

		for (int i = 0; i < 8; i++) begin
			ba = 16'(i * 16'h1111 + ($random(seed) & 32'h00ff));
			ram_ref[int'(ba)] = 8'($random(seed));
			@(posedge clk_72);
			cpu.ram_ad <= ba;
			cpu.ram_d <= ram_ref[int'(ba)];
			cpu.ram_cs <= 1'b1;
			cpu.ram_we <= 1'b1;
			settle();
			@(posedge clk_72);
			cpu.ram_we <= 1'b0;
			cpu.ram_cs <= 1'b0;
		end
		foreach (ram_ref[a]) begin
			@(posedge clk_72);
			cpu.ram_ad <= 16'(a);
			cpu.ram_cs <= 1'b1;
			cpu.ram_oe <= 1'b1;
			settle();
			settle();
			check("cpu_q_o ram", 32'(cpu_q_o), 32'(ram_ref[a]));
			@(posedge clk_72);
			cpu.ram_cs <= 1'b0;
		end
		settle();
		check("cpu_q_o cs low", 32'(cpu_q_o), 32'd0);
		@(posedge clk_72);
		cpu.ram_oe <= 1'b0;
		finish_test("cpu ram access");

		for (int i = 0; i < NTAPE; i++) begin
			tape_ref[i] = 8'($random(seed));
			@(posedge clk_72);
			dl <= '{downl: 1'b1, index: 8'd3, wr: 1'b1, addr: 25'(TBASE + 24'(i)),
				dout: tape_ref[i]};
			@(posedge clk_72);
			dl.wr <= 1'b0;
			@(negedge clk_72);
			wait_tape_idle();
		end
		@(posedge clk_72);
		dl.downl <= 1'b0;
		settle();
		check("tape_last_o", 32'(tape_last_o), 32'(TBASE + 24'(NTAPE - 1)));
		for (int i = 0; i <= NTAPE; i++) begin
			@(posedge clk_72);
			byte_addr_i <= TBASE + 24'(i);
			byte_req_i <= ~byte_req_i;
			@(negedge clk_72);
			n = 0;
			while (byte_ack_o !== byte_req_i && n < 60) begin
				@(negedge clk_72);
				n++;
			end
			if (i < NTAPE) begin
				if (n == 60) begin
					$display("tape byte %0d was never acknowledged", i);
					errors++;
				end
				check("byte_o", 32'(byte_o), 32'(tape_ref[i]));
			end else if (n != 60) begin
				$display("tape byte past the end was acknowledged at %0t", $time);
				errors++;
			end
		end
		finish_test("tape download and playback");

		for (int m = 0; m < 3; m++) begin
			for (int i = 0; i < 6; i++) begin
				@(posedge clk_72);
				status_i[9:8] <= 2'(m);
				psg.mono <= 14'($random(seed));
				psg.a <= 12'($random(seed));
				psg.b <= 12'($random(seed));
				psg.c <= 12'($random(seed));
				settle();
				ea = {2'b00, psg.a, 2'b00};
				eb = {2'b00, psg.b, 2'b00};
				ec = {2'b00, psg.c, 2'b00};
				em = {1'b0, psg.mono, 1'b0};
				check("audio_l_o", 32'(audio_l_o), m == 0 ? 32'(em) : m == 1 ? 32'(ea + eb) :
					32'(ea + ec));
				check("audio_r_o", 32'(audio_r_o), m == 0 ? 32'(em) : 32'(ec + eb));
			end
		end
		finish_test("stereo mixing");

		@(posedge clk_72);
		img_mounted_i <= 1'b1;
		img_size_i <= 32'd5;
		settle();
		check("disk_ready_o", 32'(disk_ready_o), 32'd1);
		@(posedge clk_72);
		img_mounted_i <= 1'b0;
		@(posedge clk_72);
		img_mounted_i <= 1'b1;
		img_size_i <= 32'd0;
		settle();
		check("disk_ready_o", 32'(disk_ready_o), 32'd0);
		@(posedge clk_72);
		fd_led_i <= 1'b1;
		@(negedge clk_72);
		check("led_o", 32'(led_o), 32'd0);
		@(posedge clk_72);
		fd_led_i <= 1'b0;
		@(negedge clk_72);
		check("led_o", 32'(led_o), 32'd1);
		@(posedge clk_72);
		dl <= '{downl: 1'b1, index: 8'd3, wr: 1'b0, addr: '0, dout: '0};
		@(negedge clk_72);
		check("led_o", 32'(led_o), 32'd0);
		@(posedge clk_72);
		dl.downl <= 1'b0;
		finish_test("disk ready and led");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
oric_glue_pkg.sv
machine_ctrl.sv
main_mem_port.sv
tape_fetch.sv
psg_stereo_mix.sv
oric_board_glue.sv
oric_board_glue_assert.sv
tb_oric_board_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with verilator, pass only if the log holds the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_oric_board_glue \
	-f sim.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q '^Result: PASSED$' sim.log && exit 0 || exit 1
